// ==== hdl/ram_pkg.sv ====
// 160 x 65 geometry is fixed; the MBIST pattern width must divide DATA_W - 1 evenly
`default_nettype none

package ram_pkg;

  // ------------------------------------------------------------
  // array geometry
  // ------------------------------------------------------------
  localparam int RAM_DEPTH   = 160;
  localparam int ADDR_W      = 8;
  localparam int DATA_W      = 65;
  localparam int MBIST_PAT_W = 2;

  // number of pattern copies in the lower word bits
  localparam int PAT_REPEAT  = (DATA_W - 1) / MBIST_PAT_W;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [MBIST_PAT_W-1:0] mbist_pat_t;

  // ------------------------------------------------------------
  // mbist background expansion
  // ------------------------------------------------------------
  // pattern repeated over bits 63..0, top bit takes pattern bit 0
  function automatic data_t expand_pattern(input mbist_pat_t pat);
    data_t word;
    word = {pat[0], {PAT_REPEAT{pat}}};
    return word;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/ram_port_if.sv ====
// write and read port signals toward the array; no clock inside, all fields are combinational
`default_nettype none

interface ram_port_if;
  import ram_pkg::*;

  // write port
  addr_t wa;
  data_t wd;
  logic  we;

  // read port
  addr_t ra;
  logic  re;

  // source selection side drives everything
  modport sel (
    output wa,
    output wd,
    output we,
    output ra,
    output re
  );

  // storage side only listens
  modport array (
    input wa,
    input wd,
    input we,
    input ra,
    input re
  );

endinterface

`default_nettype wire

// ==== hdl/ram_access_sel.sv ====
// mbist_en_sync must already be synchronous to clk; MBIST takes over one cycle after it is sampled
`default_nettype none

module ram_access_sel (
  input  wire                 clk,
  input  wire                 mbist_ramaccess_rst_,
  // functional ports
  input  wire ram_pkg::addr_t wa,
  input  wire ram_pkg::addr_t ra,
  input  wire ram_pkg::data_t di,
  input  wire                 we,
  input  wire                 re,
  // mbist ports
  input  wire                 mbist_en_sync,
  input  wire ram_pkg::addr_t mbist_Wa_w0,
  input  wire ram_pkg::addr_t mbist_Ra_r0,
  input  wire ram_pkg::mbist_pat_t mbist_Di_w0,
  input  wire                 mbist_we_w0,
  input  wire                 mbist_ce_r0,
  output logic                mbist_en_r,
  ram_port_if.sel             port
);
  import ram_pkg::*;

  data_t mbist_wd;

  // ------------------------------------------------------------
  // mbist mode register
  // ------------------------------------------------------------
  // functional mode after reset
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_en_r <= 1'b0;
    end else begin
      mbist_en_r <= mbist_en_sync;
    end
  end

  // 2-bit background becomes a full word
  assign mbist_wd = expand_pattern(mbist_Di_w0);

  // ------------------------------------------------------------
  // port source selection
  // ------------------------------------------------------------
  // write side
  always_comb begin
    if (mbist_en_r) begin
      port.wa = mbist_Wa_w0;
      port.wd = mbist_wd;
      port.we = mbist_we_w0;
    end else begin
      port.wa = wa;
      port.wd = di;
      port.we = we;
    end
  end

  // mbist uses its chip enable as the read strobe
  always_comb begin
    if (mbist_en_r) begin
      port.ra = mbist_Ra_r0;
      port.re = mbist_ce_r0;
    end else begin
      port.ra = ra;
      port.re = re;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ram_array.sv ====
// behavioral model of the macro; addresses 160 and up are dropped on write and read back as zero
`default_nettype none

module ram_array (
  input  wire     clk,
  input  wire     mbist_ramaccess_rst_,
  input  wire     write_inh,
  ram_port_if.array port,
  output ram_pkg::data_t rd_data
);
  import ram_pkg::*;

  // highest legal address plus one, in address width
  localparam addr_t DEPTH_LIMIT = addr_t'(RAM_DEPTH);

  data_t mem [RAM_DEPTH];

  logic wr_ok;
  logic rd_in_range;

  // ------------------------------------------------------------
  // write port
  // ------------------------------------------------------------
  // write inhibit blocks both functional and mbist writes
  assign wr_ok = port.we && !write_inh && (port.wa < DEPTH_LIMIT);

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[port.wa] <= port.wd;
    end
  end

  // ------------------------------------------------------------
  // read port
  // ------------------------------------------------------------
  assign rd_in_range = port.ra < DEPTH_LIMIT;

  // read register holds its word between reads
  // same-address write at the same edge is seen on the next read only
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      rd_data <= '0;
    end else if (port.re) begin
      if (rd_in_range) begin
        rd_data <= mem[port.ra];
      end else begin
        rd_data <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ram_read_capture.sv ====
// ore is ignored in MBIST mode; the register then loads one cycle after each mbist_ce_r0
`default_nettype none

module ram_read_capture (
  input  wire                 clk,
  input  wire                 mbist_ramaccess_rst_,
  input  wire ram_pkg::data_t rd_data,
  input  wire ram_pkg::data_t wd,
  input  wire                 ary_read_inh,
  input  wire                 ore,
  input  wire                 mbist_en_r,
  input  wire                 mbist_ce_r0,
  output ram_pkg::data_t      data_reg
);
  import ram_pkg::*;

  logic  ce_1p;
  logic  func_cap;
  logic  mbist_cap;
  logic  capture_en;
  data_t cap_src;

  // ------------------------------------------------------------
  // capture enable
  // ------------------------------------------------------------
  // mbist read data is valid one cycle after the chip enable
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      ce_1p <= 1'b0;
    end else begin
      ce_1p <= mbist_ce_r0;
    end
  end

  assign func_cap   = ore && !mbist_en_r;
  assign mbist_cap  = mbist_en_r && ce_1p;
  assign capture_en = func_cap || mbist_cap;

  // ------------------------------------------------------------
  // output data register
  // ------------------------------------------------------------
  // bypass hands the current write data straight to the output
  assign cap_src = ary_read_inh ? wd : rd_data;

  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      data_reg <= '0;
    end else if (capture_en) begin
      data_reg <= cap_src;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ram_wrap_top.sv ====
// no scan, JTAG debug or power controls; dout and mbist_Do_r0 are the same output register
`default_nettype none

module ram_wrap_top (
  input  wire                      clk,
  input  wire                      mbist_ramaccess_rst_,
  // functional write port
  input  wire ram_pkg::addr_t      wa,
  input  wire ram_pkg::data_t      di,
  input  wire                      we,
  input  wire                      write_inh,
  // functional read port
  input  wire ram_pkg::addr_t      ra,
  input  wire                      re,
  input  wire                      ore,
  input  wire                      ary_read_inh,
  // mbist access
  input  wire                      mbist_en_sync,
  input  wire ram_pkg::addr_t      mbist_Wa_w0,
  input  wire ram_pkg::addr_t      mbist_Ra_r0,
  input  wire ram_pkg::mbist_pat_t mbist_Di_w0,
  input  wire                      mbist_we_w0,
  input  wire                      mbist_ce_r0,
  // read data
  output ram_pkg::data_t           dout,
  output ram_pkg::data_t           mbist_Do_r0
);
  import ram_pkg::*;

  ram_port_if ram_port ();

  logic  mbist_en_r;
  data_t rd_data;
  data_t data_reg;

  // ------------------------------------------------------------
  // source selection
  // ------------------------------------------------------------
  ram_access_sel ram_access_sel_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .wa                   (wa),
    .ra                   (ra),
    .di                   (di),
    .we                   (we),
    .re                   (re),
    .mbist_en_sync        (mbist_en_sync),
    .mbist_Wa_w0          (mbist_Wa_w0),
    .mbist_Ra_r0          (mbist_Ra_r0),
    .mbist_Di_w0          (mbist_Di_w0),
    .mbist_we_w0          (mbist_we_w0),
    .mbist_ce_r0          (mbist_ce_r0),
    .mbist_en_r           (mbist_en_r),
    .port                 (ram_port)
  );

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  ram_array ram_array_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .write_inh            (write_inh),
    .port                 (ram_port),
    .rd_data              (rd_data)
  );

  // ------------------------------------------------------------
  // output capture
  // ------------------------------------------------------------
  // bypass source is the selected write data, so mbist data also bypasses
  ram_read_capture ram_read_capture_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .rd_data              (rd_data),
    .wd                   (ram_port.wd),
    .ary_read_inh         (ary_read_inh),
    .ore                  (ore),
    .mbist_en_r           (mbist_en_r),
    .mbist_ce_r0          (mbist_ce_r0),
    .data_reg             (data_reg)
  );

  // one register feeds both read buses
  assign dout        = data_reg;
  assign mbist_Do_r0 = data_reg;

endmodule

`default_nettype wire

// ==== sim/tb_ram_checks.svh ====
// included inside tb_ram_wrap; uses its clk, reset, check_en, exp_dout, test_name and stop_run
`ifndef TB_RAM_CHECKS_SVH
`define TB_RAM_CHECKS_SVH

// ------------------------------------------------------------
// error reporting
// ------------------------------------------------------------
`define report_mismatch(t_name, exp_v, act_v) \
  stop_run($sformatf("mismatch in %s expected %h actual %h", t_name, exp_v, act_v))

`define report_problem(why) \
  stop_run(why)

// ------------------------------------------------------------
// output checks
// ------------------------------------------------------------
// outputs change on the rising edge and are sampled on the falling one

// registers cleared during reset and until the first request
reset_dout_zero: assert property (
  @(negedge clk) reset_phase |-> (dout === data_t'(0))
) else `report_mismatch("reset dout", data_t'(0), dout);

reset_mbist_do_zero: assert property (
  @(negedge clk) reset_phase |-> (mbist_Do_r0 === data_t'(0))
) else `report_mismatch("reset mbist_Do_r0", data_t'(0), mbist_Do_r0);

// word expected from the reference model
dout_value: assert property (
  @(negedge clk) check_en |-> (dout === exp_dout)
) else `report_mismatch(test_name, exp_dout, dout);

mbist_do_value: assert property (
  @(negedge clk) check_en |-> (mbist_Do_r0 === exp_dout)
) else `report_mismatch(test_name, exp_dout, mbist_Do_r0);

// both read buses come from one register
shared_register: assert property (
  @(negedge clk) mbist_ramaccess_rst_ |-> (mbist_Do_r0 === dout)
) else `report_mismatch("shared_register", dout, mbist_Do_r0);

`endif

// ==== sim/tb_ram_wrap.sv ====
// needs a simulator with timing and concurrent assertions; reads only words written earlier since the array has no reset
`default_nettype none

module tb_ram_wrap;
  import ram_pkg::*;

  localparam int N_FUNC         = 40;
  localparam int N_INHIBIT      = 8;
  localparam int N_BYPASS       = 6;
  localparam int N_MBIST        = 20;
  localparam int N_FUNC_RECHECK = 4;
  // the sequences take roughly 500 cycles
  localparam int TIMEOUT_CYCLES = 3000;

  logic       clk;
  logic       mbist_ramaccess_rst_;
  addr_t      wa;
  data_t      di;
  logic       we;
  logic       write_inh;
  addr_t      ra;
  logic       re;
  logic       ore;
  logic       ary_read_inh;
  logic       mbist_en_sync;
  addr_t      mbist_Wa_w0;
  addr_t      mbist_Ra_r0;
  mbist_pat_t mbist_Di_w0;
  logic       mbist_we_w0;
  logic       mbist_ce_r0;
  data_t      dout;
  data_t      mbist_Do_r0;

  // checker controls
  logic       reset_phase;
  logic       check_en;
  data_t      exp_dout;
  string      test_name;
  data_t      last_out;
  int         cycle_count = 0;

  // reference model of the array contents
  data_t      model [RAM_DEPTH];
  addr_t      func_addr [N_FUNC];
  addr_t      mbist_addr [N_MBIST];

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ram_wrap_top ram_wrap_top_i (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .wa                   (wa),
    .di                   (di),
    .we                   (we),
    .write_inh            (write_inh),
    .ra                   (ra),
    .re                   (re),
    .ore                  (ore),
    .ary_read_inh         (ary_read_inh),
    .mbist_en_sync        (mbist_en_sync),
    .mbist_Wa_w0          (mbist_Wa_w0),
    .mbist_Ra_r0          (mbist_Ra_r0),
    .mbist_Di_w0          (mbist_Di_w0),
    .mbist_we_w0          (mbist_we_w0),
    .mbist_ce_r0          (mbist_ce_r0),
    .dout                 (dout),
    .mbist_Do_r0          (mbist_Do_r0)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic data_t random_word();
    return {1'($urandom), $urandom, $urandom};
  endfunction

  // every low word bit takes the pattern bit of its parity, top bit takes bit 0
  function automatic data_t mbist_word(input mbist_pat_t pat);
    data_t word;
    for (int b = 0; b < DATA_W - 1; b++) begin
      word[b] = pat[b % MBIST_PAT_W];
    end
    word[DATA_W-1] = pat[0];
    return word;
  endfunction

  // arms the output checkers for the coming falling edge
  task automatic expect_output(input string name, input data_t value);
    test_name = name;
    exp_dout <= value;
    check_en <= 1'b1;
    last_out = value;
    @(posedge clk);
    check_en <= 1'b0;
  endtask

  task automatic func_write(input addr_t addr, input data_t value, input logic inhibit);
    @(posedge clk);
    wa        <= addr;
    di        <= value;
    we        <= 1'b1;
    write_inh <= inhibit;
    @(posedge clk);
    we        <= 1'b0;
    write_inh <= 1'b0;
    if (!inhibit) begin
      model[addr] = value;
    end
  endtask

  // re in one cycle, ore in the next, word visible after the second edge
  task automatic func_read(input addr_t addr, input string name);
    @(posedge clk);
    ra  <= addr;
    re  <= 1'b1;
    @(posedge clk);
    re  <= 1'b0;
    ore <= 1'b1;
    @(posedge clk);
    ore <= 1'b0;
    expect_output(name, model[addr]);
  endtask

  task automatic bypass_read(input data_t value);
    @(posedge clk);
    di           <= value;
    ary_read_inh <= 1'b1;
    ore          <= 1'b1;
    @(posedge clk);
    ary_read_inh <= 1'b0;
    ore          <= 1'b0;
    expect_output("read_bypass", value);
  endtask

  task automatic mbist_write(input addr_t addr, input mbist_pat_t pat);
    @(posedge clk);
    mbist_Wa_w0 <= addr;
    mbist_Di_w0 <= pat;
    mbist_we_w0 <= 1'b1;
    // functional pulses that MBIST mode has to ignore
    // the write aims at a word that is read back at the end
    wa          <= func_addr[0];
    di          <= random_word();
    we          <= 1'b1;
    ore         <= 1'b1;
    @(posedge clk);
    mbist_we_w0 <= 1'b0;
    we          <= 1'b0;
    ore         <= 1'b0;
    model[addr] = mbist_word(pat);
    expect_output("mbist_ore_ignored", last_out);
  endtask

  task automatic mbist_read(input addr_t addr, input string name);
    @(posedge clk);
    mbist_Ra_r0 <= addr;
    mbist_ce_r0 <= 1'b1;
    @(posedge clk);
    mbist_ce_r0 <= 1'b0;
    @(posedge clk);
    expect_output(name, model[addr]);
  endtask

  `include "tb_ram_checks.svh"

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      `report_problem("timeout, the test sequences did not finish within the cycle limit");
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    int         i;
    mbist_pat_t pat;
    void'($urandom(58));
    mbist_ramaccess_rst_ = 1'b0;
    wa            = '0;
    di            = '0;
    we            = 1'b0;
    write_inh     = 1'b0;
    ra            = '0;
    re            = 1'b0;
    ore           = 1'b0;
    ary_read_inh  = 1'b0;
    mbist_en_sync = 1'b0;
    mbist_Wa_w0   = '0;
    mbist_Ra_r0   = '0;
    mbist_Di_w0   = '0;
    mbist_we_w0   = 1'b0;
    mbist_ce_r0   = 1'b0;
    reset_phase   = 1'b1;
    check_en      = 1'b0;
    exp_dout      = '0;
    test_name     = "idle";
    last_out      = '0;

    repeat (16) @(posedge clk);
    mbist_ramaccess_rst_ <= 1'b1;
    repeat (2) @(posedge clk);
    reset_phase <= 1'b0;

    for (i = 0; i < N_FUNC; i++) begin
      func_addr[i] = addr_t'($urandom_range(RAM_DEPTH - 1, 0));
      func_write(func_addr[i], random_word(), 1'b0);
    end
    for (i = 0; i < N_FUNC; i++) begin
      func_read(func_addr[i], "func_read");
    end

    // inhibited writes must leave the old word in place
    for (i = 0; i < N_INHIBIT; i++) begin
      func_write(func_addr[i], random_word(), 1'b1);
      func_read(func_addr[i], "write_inhibit");
    end

    for (i = 0; i < N_BYPASS; i++) begin
      bypass_read(random_word());
    end

    // MBIST owns both ports from the edge after this one
    @(posedge clk);
    mbist_en_sync <= 1'b1;
    @(posedge clk);
    for (i = 0; i < N_MBIST; i++) begin
      mbist_addr[i] = addr_t'($urandom_range(RAM_DEPTH - 1, 0));
      pat = mbist_pat_t'($urandom);
      mbist_write(mbist_addr[i], pat);
    end
    for (i = 0; i < N_MBIST; i++) begin
      mbist_read(mbist_addr[i], "mbist_read");
    end
    for (i = 0; i < N_FUNC_RECHECK; i++) begin
      mbist_read(func_addr[i], "mbist_func_word");
    end

    repeat (2) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+sim
hdl/ram_pkg.sv
hdl/ram_port_if.sv
hdl/ram_access_sel.sv
hdl/ram_array.sv
hdl/ram_read_capture.sv
hdl/ram_wrap_top.sv
sim/tb_ram_wrap.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RAM wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_ram_wrap \
  -o tb_ram_wrap > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_ram_wrap > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$SIM_LOG"; then
  exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
